// File: include/proc_config.svh
////////////////////////////////////////
// Build-wide sizes for the execution back end
// Include wherever a size is needed
////////////////////////////////////////

`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// Integer data width
`define XLEN 32

// Raw RV32 instruction word carried on the instruction bus
`define INST_BUS_W 32

// Instruction queue entries, power of two (2, 4 or 8)
`define INST_QUEUE_DEPTH 4

// Data RAM size in words, the word index wraps on this depth
`define DMEM_DEPTH 256

`endif

// File: source/proc_pkg.sv
////////////////////////////////////////
// Types and RV32I encodings shared by the back end
////////////////////////////////////////

`include "proc_config.svh"

package proc_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`INST_BUS_W-1:0] inst_t;
    typedef logic [4:0]             reg_addr_t;
    typedef logic [6:0]             opcode_t;

    // Major opcodes handled here
    localparam opcode_t R_ARITH = 7'b0110011;
    localparam opcode_t I_ARITH = 7'b0010011;
    localparam opcode_t LOAD    = 7'b0000011;
    localparam opcode_t STORE   = 7'b0100011;

    // ALU funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Width code of LW and SW
    localparam logic [2:0] F3_WORD    = 3'b010;

    // Load/store sequencer
    typedef enum logic [1:0] {
        IDLE,
        READ,
        DONE
    } lsu_state_t;

endpackage

// File: source/proc_inst_pipe.sv
////////////////////////////////////////
// Register stage on the incoming instruction bus
////////////////////////////////////////

`timescale 1ns/1ps

module proc_inst_pipe
    import proc_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  i_valid,
    output logic  o_ready,
    input  inst_t i_data,
    output logic  o_valid,
    input  logic  i_ready,
    output inst_t o_data
);

    logic  open_q;
    logic  valid_q;
    inst_t data_q;

    // Stage stays closed for the first cycle out of reset
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            open_q <= 1'b0;
        end else begin
            open_q <= 1'b1;
        end
    end

    // Room when empty or when the held word leaves this cycle
    assign o_ready = open_q && (!valid_q || i_ready);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (o_ready && i_valid) begin
            data_q <= i_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule

// File: source/proc_inst_queue.sv
////////////////////////////////////////
// Instruction FIFO between the input stage and dispatch
// Head is valid one cycle after a push, no bypass
////////////////////////////////////////

`timescale 1ns/1ps

`include "proc_config.svh"

module proc_inst_queue
    import proc_pkg::*;
(
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  i_push,
    input  inst_t i_data,
    output logic  o_full,
    input  logic  i_pull,
    output inst_t o_data,
    output logic  o_empty
);

    localparam int DEPTH = `INST_QUEUE_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    inst_t       mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pull;

    ////////////////////////////////////////
    // Status from pointer compare
    ////////////////////////////////////////

    // Same slot, opposite wrap bit means every entry is taken
    assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign o_empty = (wr_ptr == rd_ptr);

    assign do_push = i_push && !o_full;
    assign do_pull = i_pull && !o_empty;

    ////////////////////////////////////////
    // Pointers and storage
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_ptr <= '0;
        end else if (do_pull) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= i_data;
        end
    end

    assign o_data = mem[rd_ptr[AW-1:0]];

endmodule

// File: source/proc_alu.sv
////////////////////////////////////////
// Integer ALU for the OP and OP-IMM groups
// Result lands on the write port one cycle after dispatch
////////////////////////////////////////

`timescale 1ns/1ps

`include "proc_config.svh"

module proc_alu
    import proc_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  logic      i_valid,
    output logic      o_ready,
    input  inst_t     i_instbus,
    output reg_addr_t o_rs1_addr,
    output reg_addr_t o_rs2_addr,
    input  xlen_t     i_rs1_val,
    input  xlen_t     i_rs2_val,
    output logic      o_rd_wr,
    output reg_addr_t o_rd_addr,
    output xlen_t     o_rd_val
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm;
    xlen_t      op2;
    logic [4:0] shamt;
    logic       sub_op;
    logic       arith_shift;
    xlen_t      result;
    logic       rd_wr_q;

    assign opcode     = i_instbus[6:0];
    assign funct3     = i_instbus[14:12];
    assign funct7     = i_instbus[31:25];
    assign o_rs1_addr = i_instbus[19:15];
    assign o_rs2_addr = i_instbus[24:20];

    // Second operand is rs2 or the sign-extended I-immediate
    assign imm         = {{(`XLEN-12){i_instbus[31]}}, i_instbus[31:20]};
    assign op2         = (opcode == R_ARITH) ? i_rs2_val : imm;
    assign shamt       = op2[4:0];
    // SUB has no immediate form
    assign sub_op      = (opcode == R_ARITH) && funct7[5];
    assign arith_shift = funct7[5];

    always_comb begin
        case (funct3)
            F3_ADD_SUB: result = sub_op ? i_rs1_val - op2 : i_rs1_val + op2;
            F3_SLL:     result = i_rs1_val << shamt;
            F3_SLT:     result = xlen_t'($signed(i_rs1_val) < $signed(op2));
            F3_SLTU:    result = xlen_t'(i_rs1_val < op2);
            F3_XOR:     result = i_rs1_val ^ op2;
            F3_SRL_SRA: result = arith_shift ? xlen_t'($signed(i_rs1_val) >>> shamt)
                                             : i_rs1_val >> shamt;
            F3_OR:      result = i_rs1_val | op2;
            default:    result = i_rs1_val & op2;
        endcase
    end

    ////////////////////////////////////////
    // Write-back register
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_wr_q <= 1'b0;
        end else begin
            rd_wr_q <= i_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_valid) begin
            o_rd_addr <= i_instbus[11:7];
            o_rd_val  <= result;
        end
    end

    // No new work while a write is still pending
    assign o_ready = !rd_wr_q;
    assign o_rd_wr = rd_wr_q;

endmodule

// File: source/proc_lsu.sv
////////////////////////////////////////
// Word load/store unit over a local data RAM
////////////////////////////////////////

`timescale 1ns/1ps

`include "proc_config.svh"

module proc_lsu
    import proc_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       i_valid,
    output logic       o_ready,
    input  inst_t      i_instbus,
    output reg_addr_t  o_rs1_addr,
    output reg_addr_t  o_rs2_addr,
    input  xlen_t      i_rs1_val,
    input  xlen_t      i_rs2_val,
    output logic       o_rd_wr,
    output reg_addr_t  o_rd_addr,
    output xlen_t      o_rd_val,
    output logic [1:0] o_exceptions
);

    localparam int IDX_W = $clog2(`DMEM_DEPTH);

    lsu_state_t       state;
    xlen_t            mem [`DMEM_DEPTH];
    opcode_t          opcode;
    logic             is_load;
    xlen_t            imm;
    xlen_t            addr;
    logic             misaligned;
    logic             load_q;
    logic             mis_q;
    logic [IDX_W-1:0] idx_q;
    xlen_t            wdata_q;
    reg_addr_t        rd_q;
    xlen_t            rd_val_q;

    assign opcode     = i_instbus[6:0];
    assign is_load    = (opcode == LOAD);
    assign o_rs1_addr = i_instbus[19:15];
    assign o_rs2_addr = i_instbus[24:20];

    // I-form offset for loads, S-form for stores
    assign imm = is_load ? {{(`XLEN-12){i_instbus[31]}}, i_instbus[31:20]}
                         : {{(`XLEN-12){i_instbus[31]}}, i_instbus[31:25], i_instbus[11:7]};
    assign addr       = i_rs1_val + imm;
    assign misaligned = |addr[1:0];

    ////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state  <= IDLE;
            load_q <= 1'b0;
            mis_q  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (i_valid) begin
                        state  <= READ;
                        load_q <= is_load;
                        mis_q  <= misaligned;
                    end
                end
                // Only a good load needs the extra write-back cycle
                READ:    state <= (load_q && !mis_q) ? DONE : IDLE;
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == IDLE && i_valid) begin
            idx_q   <= addr[IDX_W+1:2];
            wdata_q <= i_rs2_val;
            rd_q    <= i_instbus[11:7];
        end
    end

    ////////////////////////////////////////
    // Data RAM
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (state == READ && !load_q && !mis_q) begin
            mem[idx_q] <= wdata_q;
        end
    end

    always_ff @(posedge aclk) begin
        if (state == READ) begin
            rd_val_q <= mem[idx_q];
        end
    end

    assign o_ready         = (state == IDLE);
    assign o_rd_wr         = (state == DONE);
    assign o_rd_addr       = rd_q;
    assign o_rd_val        = rd_val_q;
    // Bit 0 for a load, bit 1 for a store
    assign o_exceptions[0] = (state == READ) && mis_q && load_q;
    assign o_exceptions[1] = (state == READ) && mis_q && !load_q;

endmodule

// File: source/proc_processing.sv
////////////////////////////////////////
// Execution back end top, instruction input to register write ports
// Port 0 of the register file is the ALU, port 1 the load/store unit
////////////////////////////////////////

`timescale 1ns/1ps

module proc_processing
    import proc_pkg::*;
(
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  i_proc_valid,
    output logic                  o_proc_ready,
    input  inst_t                 i_proc_instbus,
    output logic                  o_busy,
    output reg_addr_t [1:0]       o_rs1_addr,
    output reg_addr_t [1:0]       o_rs2_addr,
    input  xlen_t     [1:0]       i_rs1_val,
    input  xlen_t     [1:0]       i_rs2_val,
    output logic      [1:0]       o_rd_wr,
    output reg_addr_t [1:0]       o_rd_addr,
    output xlen_t     [1:0]       o_rd_val,
    output logic      [1:0]       o_exceptions
);

    logic       pipe_valid;
    inst_t      pipe_data;
    logic       queue_full;
    logic       queue_empty;
    inst_t      head;
    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alu_inst;
    logic       ls_inst;
    logic       dispatch;
    logic       alu_valid;
    logic       alu_ready;
    logic       lsu_valid;
    logic       lsu_ready;

    proc_inst_pipe u_pipe (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_valid (i_proc_valid),
        .o_ready (o_proc_ready),
        .i_data  (i_proc_instbus),
        .o_valid (pipe_valid),
        .i_ready (!queue_full),
        .o_data  (pipe_data)
    );

    proc_inst_queue u_queue (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_push  (pipe_valid),
        .i_data  (pipe_data),
        .o_full  (queue_full),
        .i_pull  (dispatch),
        .o_data  (head),
        .o_empty (queue_empty)
    );

    ////////////////////////////////////////
    // Decode and dispatch
    ////////////////////////////////////////

    assign opcode = head[6:0];
    assign funct3 = head[14:12];
    assign funct7 = head[31:25];

    assign alu_inst = (opcode == R_ARITH && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) ||
                      (opcode == I_ARITH);
    // Word accesses only, other widths fall through as unknown
    assign ls_inst  = (opcode == LOAD || opcode == STORE) && (funct3 == F3_WORD);

    // Waiting on both units keeps results in program order
    assign dispatch  = !queue_empty && alu_ready && lsu_ready;
    assign alu_valid = dispatch && alu_inst;
    assign lsu_valid = dispatch && ls_inst;

    proc_alu u_alu (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_valid    (alu_valid),
        .o_ready    (alu_ready),
        .i_instbus  (head),
        .o_rs1_addr (o_rs1_addr[0]),
        .o_rs2_addr (o_rs2_addr[0]),
        .i_rs1_val  (i_rs1_val[0]),
        .i_rs2_val  (i_rs2_val[0]),
        .o_rd_wr    (o_rd_wr[0]),
        .o_rd_addr  (o_rd_addr[0]),
        .o_rd_val   (o_rd_val[0])
    );

    proc_lsu u_lsu (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_valid      (lsu_valid),
        .o_ready      (lsu_ready),
        .i_instbus    (head),
        .o_rs1_addr   (o_rs1_addr[1]),
        .o_rs2_addr   (o_rs2_addr[1]),
        .i_rs1_val    (i_rs1_val[1]),
        .i_rs2_val    (i_rs2_val[1]),
        .o_rd_wr      (o_rd_wr[1]),
        .o_rd_addr    (o_rd_addr[1]),
        .o_rd_val     (o_rd_val[1]),
        .o_exceptions (o_exceptions)
    );

    // Anything in flight anywhere keeps the back end busy
    assign o_busy = pipe_valid || !queue_empty || !alu_ready || !lsu_ready;

endmodule

// File: verification/proc_assert.sv
////////////////////////////////////////
// Handshake and write-port rules, bound onto the back end top
////////////////////////////////////////

`timescale 1ns/1ps

module proc_assert
    import proc_pkg::*;
(
    input logic       aclk,
    input logic       aresetn,
    input logic       i_proc_valid,
    input logic       o_proc_ready,
    input inst_t      i_proc_instbus,
    input logic       o_busy,
    input logic [1:0] o_rd_wr,
    input logic [1:0] o_exceptions
);

    // Number of failed properties so far
    int unsigned fail_count = 0;

    hold_until_ready: assert property (@(posedge aclk) disable iff (!aresetn)
        i_proc_valid && !o_proc_ready |=> i_proc_valid && $stable(i_proc_instbus))
    else begin
        $error("instruction withdrawn or changed while ready was low");
        fail_count++;
    end

    // At most one write or exception per cycle
    one_result: assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0({o_rd_wr, o_exceptions}))
    else begin
        $error("write strobes and exception bits overlap");
        fail_count++;
    end

    quiet_after_reset: assert property (@(posedge aclk)
        $rose(aresetn) |-> (o_rd_wr == 2'b00) && (o_exceptions == 2'b00) && !o_busy)
    else begin
        $error("outputs not idle when reset is released");
        fail_count++;
    end

endmodule

bind proc_processing proc_assert u_assert (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .i_proc_valid   (i_proc_valid),
    .o_proc_ready   (o_proc_ready),
    .i_proc_instbus (i_proc_instbus),
    .o_busy         (o_busy),
    .o_rd_wr        (o_rd_wr),
    .o_exceptions   (o_exceptions)
);

// File: verification/proc_tb.sv
////////////////////////////////////////
// Random RV32I instruction stream checked against a shadow model
////////////////////////////////////////

`timescale 1ns/1ps

`include "proc_config.svh"

module proc_tb
    import proc_pkg::*;
();

    localparam int  PERIOD       = 100;
    localparam int  DRIVE_DELAY  = 10;
    localparam int  RESET_CYCLES = 4;
    localparam int  NUM_INST     = 400;
    localparam int  DRAIN_CYCLES = 20;
    localparam time WATCHDOG     = NUM_INST * 8 * PERIOD + RESET_CYCLES * PERIOD;

    // Kind 0 and 1 are the write ports, kind 2 an exception pulse
    typedef struct packed {
        logic [1:0] kind;
        reg_addr_t  rd;
        xlen_t      val;
        logic [1:0] exc;
    } expect_t;

    logic            aclk;
    logic            aresetn;
    logic            proc_valid;
    logic            proc_ready;
    inst_t           instbus;
    logic            busy;
    reg_addr_t [1:0] rs1_addr;
    reg_addr_t [1:0] rs2_addr;
    xlen_t     [1:0] rs1_val;
    xlen_t     [1:0] rs2_val;
    logic      [1:0] rd_wr;
    reg_addr_t [1:0] rd_addr;
    xlen_t     [1:0] rd_val;
    logic      [1:0] exceptions;

    xlen_t       regs [32];
    xlen_t       shadow_regs [32];
    xlen_t       shadow_mem [`DMEM_DEPTH];
    expect_t     exp_q [$];
    int unsigned seen_events  = 0;
    int unsigned full_stalls  = 0;

    proc_processing DUT (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_proc_valid   (proc_valid),
        .o_proc_ready   (proc_ready),
        .i_proc_instbus (instbus),
        .o_busy         (busy),
        .o_rs1_addr     (rs1_addr),
        .o_rs2_addr     (rs2_addr),
        .i_rs1_val      (rs1_val),
        .i_rs2_val      (rs2_val),
        .o_rd_wr        (rd_wr),
        .o_rd_addr      (rd_addr),
        .o_rd_val       (rd_val),
        .o_exceptions   (exceptions)
    );

    initial aclk = 1'b0;
    always #(PERIOD / 2) aclk = ~aclk;

    ////////////////////////////////////////
    // Register file model
    ////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rs1_val[p] = regs[rs1_addr[p]];
            rs2_val[p] = regs[rs2_addr[p]];
        end
    end

    always @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                // x0 is hardwired
                if (rd_wr[p] && rd_addr[p] != 5'd0) begin
                    regs[rd_addr[p]] <= rd_val[p];
                end
            end
        end
    end

    ////////////////////////////////////////
    // Checking
    ////////////////////////////////////////

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_rd(input int port, input reg_addr_t exp_addr, input reg_addr_t got_addr,
                            input xlen_t exp_val, input xlen_t got_val);
        if (got_addr !== exp_addr) begin
            $display("CHECK FAILED at %0t: o_rd_addr[%0d] expected %0d got %0d",
                     $time, port, exp_addr, got_addr);
            stop_on_failure();
        end else if (got_val !== exp_val) begin
            $display("CHECK FAILED at %0t: o_rd_val[%0d] expected %h got %h",
                     $time, port, exp_val, got_val);
            stop_on_failure();
        end
    endtask

    task automatic check_exc(input logic [1:0] exp_exc, input logic [1:0] got_exc);
        if (got_exc !== exp_exc) begin
            $display("CHECK FAILED at %0t: o_exceptions expected %b got %b",
                     $time, exp_exc, got_exc);
            stop_on_failure();
        end
    endtask

    task automatic take_expected(input logic [1:0] kind);
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("ERROR: result at %0t with no instruction left to explain it", $time);
            stop_on_failure();
        end else begin
            e = exp_q.pop_front();
            seen_events++;
            if (e.kind != kind) begin
                $display("ERROR: result at %0t is of kind %0d, the model expected kind %0d",
                         $time, kind, e.kind);
                stop_on_failure();
            end else if (kind == 2'd2) begin
                check_exc(e.exc, exceptions);
            end else begin
                check_rd(int'(kind), e.rd, rd_addr[kind], e.val, rd_val[kind]);
            end
        end
    endtask

    // Outputs settle between edges, so look at them on the falling edge
    always @(negedge aclk) begin
        if (aresetn) begin
            if (DUT.u_assert.fail_count != 0) begin
                $display("ERROR: a bound assertion failed before %0t", $time);
                stop_on_failure();
            end else begin
                if (rd_wr[0]) take_expected(2'd0);
                if (rd_wr[1]) take_expected(2'd1);
                if (exceptions != 2'b00) take_expected(2'd2);
            end
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic xlen_t alu_result(input logic [2:0] f3, input logic sub, input logic sra,
                                         input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? xlen_t'(1) : xlen_t'(0);
            3'b011:  return (a < b) ? xlen_t'(1) : xlen_t'(0);
            3'b100:  return a ^ b;
            3'b101:  return sra ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic run_model(input inst_t inst);
        opcode_t     op;
        reg_addr_t   rd;
        xlen_t       a;
        xlen_t       b;
        xlen_t       addr;
        int unsigned idx;
        expect_t     e;
        op   = inst[6:0];
        rd   = inst[11:7];
        a    = shadow_regs[inst[19:15]];
        b    = shadow_regs[inst[24:20]];
        e    = '0;
        e.rd = rd;
        if (op == R_ARITH || op == I_ARITH) begin
            if (op == I_ARITH) b = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            e.kind = 2'd0;
            e.val  = alu_result(inst[14:12], op == R_ARITH && inst[30], inst[30], a, b);
        end else if ((op == LOAD || op == STORE) && inst[14:12] == F3_WORD) begin
            if (op == LOAD) begin
                addr = a + {{(`XLEN-12){inst[31]}}, inst[31:20]};
            end else begin
                addr = a + {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            idx = (addr >> 2) % `DMEM_DEPTH;
            if (addr[1:0] != 2'b00) begin
                e.kind = 2'd2;
                e.exc  = (op == LOAD) ? 2'b01 : 2'b10;
            end else if (op == LOAD) begin
                e.kind = 2'd1;
                e.val  = shadow_mem[idx];
            end else begin
                shadow_mem[idx] = b;
                return;
            end
        end else begin
            // Unknown opcode leaves no trace
            return;
        end
        if (e.kind != 2'd2 && rd != 5'd0) shadow_regs[rd] = e.val;
        exp_q.push_back(e);
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    function automatic inst_t make_inst();
        int unsigned cls;
        logic [31:0] r;
        logic [31:0] r2;
        logic [6:0]  funct7;
        logic [2:0]  f3;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm;
        opcode_t     op;
        cls = $urandom_range(99);
        r   = $urandom;
        // Sixteen registers keep dependencies frequent
        rd  = {1'b0, r[3:0]};
        rs1 = {1'b0, r[7:4]};
        rs2 = {1'b0, r[11:8]};
        f3  = r[14:12];
        imm = r[26:15];
        funct7 = ((f3 == 3'b000 || f3 == 3'b101) && r[27]) ? 7'h20 : 7'h00;
        if (cls < 30) begin
            return {funct7, rs2, rs1, f3, rd, R_ARITH};
        end else if (cls < 55) begin
            if (f3 == 3'b001 || f3 == 3'b101) imm = {funct7, imm[4:0]};
            return {imm, rs1, f3, rd, I_ARITH};
        end else if (cls < 85) begin
            // Small word window so stores and loads meet
            imm = {6'd0, r[19:16], 2'b00};
            if (r[22:20] == 3'd0) imm[1:0] = r[24:23] | 2'b01;
            if (r[27:25] != 3'd0) rs1 = 5'd0;
            if (cls < 70) return {imm, rs1, F3_WORD, rd, LOAD};
            return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], STORE};
        end
        do begin
            r2 = $urandom;
            op = r2[6:0];
        end while (op == R_ARITH || op == I_ARITH || op == LOAD || op == STORE);
        return {r[31:7], op};
    endfunction

    task automatic send(input inst_t inst, input int unsigned gap);
        logic taken;
        if (gap != 0) proc_valid = 1'b0;
        repeat (gap) begin
            @(posedge aclk);
            #DRIVE_DELAY;
        end
        proc_valid = 1'b1;
        instbus    = inst;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge aclk);
            taken = proc_ready;
            if (!proc_ready && DUT.queue_full) full_stalls++;
            @(posedge aclk);
            #DRIVE_DELAY;
        end
    endtask

    initial begin
        inst_t       inst;
        int unsigned gap;
        string       why;
        void'($urandom(32'h0155dac2));
        aresetn    = 1'b0;
        proc_valid = 1'b0;
        instbus    = '0;
        why        = "";
        for (int i = 0; i < 32; i++) begin
            shadow_regs[i] = '0;
        end
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            shadow_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        #DRIVE_DELAY;
        aresetn = 1'b1;
        for (int n = 0; n < NUM_INST; n++) begin
            inst = make_inst();
            // Mostly back to back, now and then a short idle stretch
            gap  = ($urandom_range(3) == 0) ? $urandom_range(6, 1) : 0;
            send(inst, gap);
            run_model(inst);
        end
        proc_valid = 1'b0;
        repeat (DRAIN_CYCLES) @(posedge aclk);
        @(negedge aclk);
        if (exp_q.size() != 0) begin
            why = "results still missing after the drain period";
        end else if (busy !== 1'b0) begin
            why = "o_busy still high after the drain period";
        end else if (full_stalls == 0) begin
            why = "o_proc_ready never dropped while the queue was full";
        end
        if (why == "") begin
            $display("%0d instructions, %0d results, %0d full-queue stalls",
                     NUM_INST, seen_events, full_stalls);
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("ERROR: %s", why);
            stop_on_failure();
        end
    end

    initial begin
        #(WATCHDOG);
        $display("ERROR: watchdog expired before the run finished");
        stop_on_failure();
    end

endmodule

// File: list.f
+incdir+include
source/proc_pkg.sv
source/proc_inst_pipe.sv
source/proc_inst_queue.sv
source/proc_alu.sv
source/proc_lsu.sv
source/proc_processing.sv
verification/proc_assert.sv
verification/proc_tb.sv

// File: Makefile
TOP := proc_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^Test completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log
